// ==== design/mpf_pkg.sv ====
package mpf_pkg;

    // ========================================================================
    // Sizes and flow-control constants
    // ========================================================================

    // Entries in the write-data heap at the AFU edge
    localparam int HEAP_ENTRIES = 32;

    // A sender may issue this many requests after it sees almost-full
    localparam int TX_ALM_FULL_THRESHOLD = 4;

    // Longest legal write packet, in beats
    localparam int MAX_MULTI_LINE_BEATS = 4;

    // The heap must still absorb a full packet plus the requests in flight
    // after almost-full, since the flag never rises inside a packet
    localparam int HEAP_MIN_FREE = TX_ALM_FULL_THRESHOLD + MAX_MULTI_LINE_BEATS + 1;

    // Header FIFO at the FIU edge, two slots above the threshold
    localparam int FIFO_ENTRIES = TX_ALM_FULL_THRESHOLD + 2;

    // ========================================================================
    // Field types
    // ========================================================================

    // Cache-line address
    typedef logic [31:0] cl_addr_t;

    // One beat of line data
    typedef logic [63:0] cl_data_t;

    // Beat count minus one: 0, 1 or 3 (2 is illegal)
    typedef logic [1:0] cl_len_t;

    // Beat number inside a packet
    typedef logic [1:0] cl_num_t;

    // Index of an entry in the write-data heap
    typedef logic [$clog2(HEAP_ENTRIES)-1:0] heap_idx_t;

    // Width of a write header held in the FIU-side FIFO: address, length and
    // the heap index that stands in for the data
    localparam int C1_HDR_BITS = $bits(cl_addr_t) + $bits(cl_len_t) + $bits(heap_idx_t);

endpackage

// ==== design/mpf_chan_if.sv ====
`timescale 1ns/1ps

interface mpf_chan_if;
    import mpf_pkg::*;

    // Read request channel
    logic     c0_valid;
    cl_addr_t c0_addr;
    cl_len_t  c0_len;

    // Write request channel, one beat per valid cycle
    logic     c1_valid;
    logic     c1_sop;
    cl_addr_t c1_addr;
    cl_len_t  c1_len;
    cl_data_t c1_data;

    // Flow control back toward the request source
    logic     c0_alm_full;
    logic     c1_alm_full;

    // Port of a block that sends requests toward the host
    modport to_fiu
    (
        output c0_valid, c0_addr, c0_len,
        output c1_valid, c1_sop, c1_addr, c1_len, c1_data,
        input  c0_alm_full, c1_alm_full
    );

    // Port of a block that accepts requests from the accelerator
    modport to_afu
    (
        input  c0_valid, c0_addr, c0_len,
        input  c1_valid, c1_sop, c1_addr, c1_len, c1_data,
        output c0_alm_full, c1_alm_full
    );

endinterface

// ==== design/write_data_heap.sv ====
`timescale 1ns/1ps

module write_data_heap
#(
    parameter int N_ENTRIES   = mpf_pkg::HEAP_ENTRIES,
    parameter int N_DATA_BITS = $bits(mpf_pkg::cl_data_t)
)
(
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         enq,
    input  logic [N_DATA_BITS-1:0]       enq_data,
    output logic                         not_full,
    output logic [$clog2(N_ENTRIES)-1:0] alloc_idx,
    input  logic [$clog2(N_ENTRIES)-1:0] read_idx,
    output logic [N_DATA_BITS-1:0]       read_data,
    input  logic                         free,
    input  logic [$clog2(N_ENTRIES)-1:0] free_idx
);
    import mpf_pkg::*;

    logic [N_DATA_BITS-1:0]         mem [N_ENTRIES];
    logic [N_ENTRIES-1:0]           busy;
    logic [$clog2(N_ENTRIES+1)-1:0] busy_cnt;
    logic [$clog2(N_ENTRIES)-1:0]   read_idx_q;
    logic                           free_ok;

    // A free only counts when the entry is really held
    assign free_ok = free && busy[free_idx];

    // Space for a whole packet plus the in-flight requests must remain
    assign not_full = (busy_cnt <= N_ENTRIES - HEAP_MIN_FREE);

    // ========================================================================
    // Allocation and release
    // ========================================================================

    // Entries are handed out in circular order, which matches the order in
    // which the FIU side drains them
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            alloc_idx <= '0;
            busy      <= '0;
            busy_cnt  <= '0;
        end
        else
        begin
            if (free_ok)
                busy[free_idx] <= 1'b0;
            if (enq)
            begin
                busy[alloc_idx] <= 1'b1;
                alloc_idx <= alloc_idx + 1'b1;
            end

            case ({enq, free_ok})
                2'b10:   busy_cnt <= busy_cnt + 1'b1;
                2'b01:   busy_cnt <= busy_cnt - 1'b1;
                default: busy_cnt <= busy_cnt;
            endcase
        end
    end

    // ========================================================================
    // Storage and read port
    // ========================================================================

    always_ff @(posedge clk)
    begin
        if (enq)
            mem[alloc_idx] <= enq_data;
    end

    // Two-cycle read: the index is registered first, then the data
    always_ff @(posedge clk)
    begin
        read_idx_q <= read_idx;
        read_data  <= mem[read_idx_q];
    end

endmodule

// ==== design/lutram_fifo.sv ====
`timescale 1ns/1ps

module lutram_fifo
#(
    parameter int N_ENTRIES   = mpf_pkg::FIFO_ENTRIES,
    parameter int N_DATA_BITS = mpf_pkg::C1_HDR_BITS,
    parameter int THRESHOLD   = mpf_pkg::TX_ALM_FULL_THRESHOLD
)
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   enq_en,
    input  logic [N_DATA_BITS-1:0] enq_data,
    output logic                   almost_full,
    output logic [N_DATA_BITS-1:0] first,
    input  logic                   deq_en,
    output logic                   not_empty
);

    logic [N_DATA_BITS-1:0]         mem [N_ENTRIES];
    logic [$clog2(N_ENTRIES)-1:0]   wr_ptr;
    logic [$clog2(N_ENTRIES)-1:0]   rd_ptr;
    logic [$clog2(N_ENTRIES+1)-1:0] level;

    // The head entry is visible without a dequeue request
    assign first     = mem[rd_ptr];
    assign not_empty = (level != '0);

    // Raised once THRESHOLD or fewer slots remain
    assign almost_full = (level >= N_ENTRIES - THRESHOLD);

    always_ff @(posedge clk)
    begin
        if (enq_en)
            mem[wr_ptr] <= enq_data;
    end

    // Pointers wrap explicitly since the depth need not be a power of two
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end
        else
        begin
            if (enq_en)
                wr_ptr <= (int'(wr_ptr) == N_ENTRIES - 1) ? '0 : wr_ptr + 1'b1;
            if (deq_en)
                rd_ptr <= (int'(rd_ptr) == N_ENTRIES - 1) ? '0 : rd_ptr + 1'b1;

            case ({enq_en, deq_en})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

endmodule

// ==== design/multi_write_tracker.sv ====
`timescale 1ns/1ps

module multi_write_tracker
(
    input  logic             clk,
    input  logic             reset,
    input  logic             c1_valid,
    input  logic             c1_sop,
    input  mpf_pkg::cl_len_t c1_len,
    output logic             packet_active
);
    import mpf_pkg::*;

    // Beats still expected after the ones seen so far
    cl_num_t beats_rem;

    always_ff @(posedge clk)
    begin
        if (reset)
            beats_rem <= '0;
        else if (c1_valid)
        begin
            // A start beat loads the count of the beats that follow it
            if (c1_sop)
                beats_rem <= c1_len;
            else if (beats_rem != '0)
                beats_rem <= beats_rem - 1'b1;
        end
    end

    // Single-beat packets never make the tracker active
    assign packet_active = (beats_rem != '0);

endmodule

// ==== design/edge_connect.sv ====
`timescale 1ns/1ps

module edge_connect
(
    input  logic      clk,
    input  logic      reset,
    mpf_chan_if.to_fiu fiu_edge,
    mpf_chan_if.to_afu afu_edge,
    mpf_chan_if.to_afu fiu,
    mpf_chan_if.to_fiu afu
);
    import mpf_pkg::*;

    // Heap ports
    logic      heap_not_full;
    heap_idx_t heap_alloc_idx;
    cl_data_t  heap_read_data;
    logic      heap_deq_en;
    logic      heap_deq_en_q;
    heap_idx_t heap_deq_idx;
    heap_idx_t heap_deq_idx_q;
    logic      heap_data_rdy;

    // Header FIFO ports and the unpacked head entry
    logic [C1_HDR_BITS-1:0] fifo_first;
    logic                   fifo_deq;
    logic                   fifo_not_empty;
    cl_addr_t               first_addr;
    cl_len_t                first_len;
    heap_idx_t              first_idx;

    // Beat regeneration pipeline
    logic     wr_may_fire;
    logic     stg1_packet_done;
    logic     stg1_valid;
    logic     stg1_sop;
    cl_addr_t stg1_addr;
    cl_len_t  stg1_len;
    cl_num_t  stg1_beat_idx;
    cl_num_t  stg1_beats_rem;
    logic     stg2_valid;
    logic     stg2_sop;
    cl_addr_t stg2_addr;
    cl_len_t  stg2_len;
    logic     stg3_valid;
    logic     stg3_sop;
    cl_addr_t stg3_addr;
    cl_len_t  stg3_len;

    logic afu_packet_active;

    // Every AFU write beat lands in the heap, the FIU side frees it later
    write_data_heap
    #(
        .N_ENTRIES   (HEAP_ENTRIES),
        .N_DATA_BITS ($bits(cl_data_t))
    )
    i_heap
    (
        .clk       (clk),
        .reset     (reset),
        .enq       (afu_edge.c1_valid),
        .enq_data  (afu_edge.c1_data),
        .not_full  (heap_not_full),
        .alloc_idx (heap_alloc_idx),
        .read_idx  (heap_deq_idx),
        .read_data (heap_read_data),
        .free      (heap_deq_en_q),
        .free_idx  (heap_deq_idx_q)
    );

    // ========================================================================
    // FIU edge
    // ========================================================================

    // Reads take one register stage and nothing else
    always_ff @(posedge clk)
    begin
        if (reset)
            fiu_edge.c0_valid <= 1'b0;
        else
            fiu_edge.c0_valid <= fiu.c0_valid;
        fiu_edge.c0_addr <= fiu.c0_addr;
        fiu_edge.c0_len  <= fiu.c0_len;
    end

    assign fiu.c0_alm_full = fiu_edge.c0_alm_full;

    // Only start headers are queued, the index rides in the low data bits
    lutram_fifo
    #(
        .N_ENTRIES   (FIFO_ENTRIES),
        .N_DATA_BITS (C1_HDR_BITS),
        .THRESHOLD   (TX_ALM_FULL_THRESHOLD)
    )
    i_hdr_fifo
    (
        .clk         (clk),
        .reset       (reset),
        .enq_en      (fiu.c1_valid && fiu.c1_sop),
        .enq_data    ({fiu.c1_addr, fiu.c1_len, heap_idx_t'(fiu.c1_data)}),
        .almost_full (fiu.c1_alm_full),
        .first       (fifo_first),
        .deq_en      (fifo_deq),
        .not_empty   (fifo_not_empty)
    );

    assign {first_addr, first_len, first_idx} = fifo_first;

    always_comb
    begin
        // A beat may go when its heap data exists and the host has room
        wr_may_fire = !fiu_edge.c1_alm_full && heap_data_rdy;
        stg1_packet_done = wr_may_fire && (stg1_beats_rem == '0);
        heap_deq_en = wr_may_fire && stg1_valid;
        // Load the next header once the stage is empty or finishing
        fifo_deq = fifo_not_empty && (stg1_packet_done || !stg1_valid);
    end

    // Stage 1 walks the beats of the current packet
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            stg1_valid     <= 1'b0;
            stg1_sop       <= 1'b1;
            stg1_beat_idx  <= '0;
            stg1_beats_rem <= '0;
            heap_data_rdy  <= 1'b0;
        end
        else if (fifo_deq)
        begin
            stg1_valid     <= 1'b1;
            stg1_addr      <= first_addr;
            stg1_len       <= first_len;
            stg1_sop       <= 1'b1;
            stg1_beat_idx  <= '0;
            stg1_beats_rem <= first_len;
            // The start beat was stored before its header entered the FIFO
            heap_data_rdy  <= 1'b1;
            heap_deq_idx   <= first_idx;
        end
        else if (stg1_packet_done)
        begin
            stg1_valid    <= 1'b0;
            heap_data_rdy <= 1'b0;
        end
        else if (heap_deq_en)
        begin
            stg1_sop       <= 1'b0;
            stg1_beat_idx  <= stg1_beat_idx + 1'b1;
            stg1_beats_rem <= stg1_beats_rem - 1'b1;
            heap_deq_idx   <= heap_deq_idx + 1'b1;
            // Later beats may still be on their way from the AFU
            heap_data_rdy  <= ((heap_deq_idx + 1'b1) != heap_alloc_idx);
        end
        else
            heap_data_rdy <= stg1_valid && (heap_deq_idx != heap_alloc_idx);
    end

    // Stages 2 and 3 cover the heap read latency
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            stg2_valid    <= 1'b0;
            stg3_valid    <= 1'b0;
            heap_deq_en_q <= 1'b0;
        end
        else
        begin
            stg2_valid    <= heap_deq_en;
            stg3_valid    <= stg2_valid;
            heap_deq_en_q <= heap_deq_en;
        end

        if (wr_may_fire)
        begin
            stg2_sop  <= stg1_sop;
            stg2_len  <= stg1_len;
            // Aligned base address, so OR gives the address of this beat
            stg2_addr <= {stg1_addr[$bits(cl_addr_t)-1:$bits(cl_num_t)],
                          stg1_addr[$bits(cl_num_t)-1:0] | stg1_beat_idx};
        end
        stg3_sop       <= stg2_sop;
        stg3_addr      <= stg2_addr;
        stg3_len       <= stg2_len;
        heap_deq_idx_q <= heap_deq_idx;
    end

    // Header from stage 3 meets the heap output register here
    assign fiu_edge.c1_valid = stg3_valid;
    assign fiu_edge.c1_sop   = stg3_sop;
    assign fiu_edge.c1_addr  = stg3_addr;
    assign fiu_edge.c1_len   = stg3_len;
    assign fiu_edge.c1_data  = heap_read_data;

    // ========================================================================
    // AFU edge
    // ========================================================================

    assign afu.c0_valid = afu_edge.c0_valid;
    assign afu.c0_addr  = afu_edge.c0_addr;
    assign afu.c0_len   = afu_edge.c0_len;

    // Only start beats enter the pipeline, carrying their heap index
    assign afu.c1_valid = afu_edge.c1_valid && afu_edge.c1_sop;
    assign afu.c1_sop   = afu_edge.c1_sop;
    assign afu.c1_addr  = afu_edge.c1_addr;
    assign afu.c1_len   = afu_edge.c1_len;
    assign afu.c1_data  = cl_data_t'(heap_alloc_idx);

    multi_write_tracker i_wr_track
    (
        .clk           (clk),
        .reset         (reset),
        .c1_valid      (afu_edge.c1_valid),
        .c1_sop        (afu_edge.c1_sop),
        .c1_len        (afu_edge.c1_len),
        .packet_active (afu_packet_active)
    );

    assign afu_edge.c0_alm_full = afu.c0_alm_full;

    // Held low inside a packet, its header is already in flight and the
    // remaining beats must be accepted to avoid deadlock
    assign afu_edge.c1_alm_full = (afu.c1_alm_full || !heap_not_full) &&
                                  !afu_packet_active;

endmodule

// ==== design/mpf_edge_top.sv ====
`timescale 1ns/1ps

module mpf_edge_top
(
    input  logic              clk,
    input  logic              reset,

    // AFU side
    input  logic              afu_c0_valid,
    input  mpf_pkg::cl_addr_t afu_c0_addr,
    input  mpf_pkg::cl_len_t  afu_c0_len,
    output logic              afu_c0_alm_full,
    input  logic              afu_c1_valid,
    input  logic              afu_c1_sop,
    input  mpf_pkg::cl_addr_t afu_c1_addr,
    input  mpf_pkg::cl_len_t  afu_c1_len,
    input  mpf_pkg::cl_data_t afu_c1_data,
    output logic              afu_c1_alm_full,

    // FIU side
    output logic              fiu_c0_valid,
    output mpf_pkg::cl_addr_t fiu_c0_addr,
    output mpf_pkg::cl_len_t  fiu_c0_len,
    input  logic              fiu_c0_alm_full,
    output logic              fiu_c1_valid,
    output logic              fiu_c1_sop,
    output mpf_pkg::cl_addr_t fiu_c1_addr,
    output mpf_pkg::cl_len_t  fiu_c1_len,
    output mpf_pkg::cl_data_t fiu_c1_data,
    input  logic              fiu_c1_alm_full
);

    mpf_chan_if afu_side ();
    mpf_chan_if fiu_side ();

    // Empty pipeline: the edge's two inner ports meet on one bundle
    mpf_chan_if pipe ();

    assign afu_side.c0_valid = afu_c0_valid;
    assign afu_side.c0_addr  = afu_c0_addr;
    assign afu_side.c0_len   = afu_c0_len;
    assign afu_side.c1_valid = afu_c1_valid;
    assign afu_side.c1_sop   = afu_c1_sop;
    assign afu_side.c1_addr  = afu_c1_addr;
    assign afu_side.c1_len   = afu_c1_len;
    assign afu_side.c1_data  = afu_c1_data;
    assign afu_c0_alm_full   = afu_side.c0_alm_full;
    assign afu_c1_alm_full   = afu_side.c1_alm_full;

    assign fiu_c0_valid         = fiu_side.c0_valid;
    assign fiu_c0_addr          = fiu_side.c0_addr;
    assign fiu_c0_len           = fiu_side.c0_len;
    assign fiu_c1_valid         = fiu_side.c1_valid;
    assign fiu_c1_sop           = fiu_side.c1_sop;
    assign fiu_c1_addr          = fiu_side.c1_addr;
    assign fiu_c1_len           = fiu_side.c1_len;
    assign fiu_c1_data          = fiu_side.c1_data;
    assign fiu_side.c0_alm_full = fiu_c0_alm_full;
    assign fiu_side.c1_alm_full = fiu_c1_alm_full;

    edge_connect i_edge
    (
        .clk      (clk),
        .reset    (reset),
        .fiu_edge (fiu_side.to_fiu),
        .afu_edge (afu_side.to_afu),
        .fiu      (pipe.to_afu),
        .afu      (pipe.to_fiu)
    );

endmodule

// ==== testbench/tb_mpf_edge.sv ====
`timescale 1ns/1ps

module tb_mpf_edge;
    import mpf_pkg::*;

    // ========================================================================
    // Run length follows from the number of requests and the longest packet
    // ========================================================================

    localparam int N_REQUESTS   = 200;
    localparam int CYCLE_LIMIT  = N_REQUESTS * MAX_MULTI_LINE_BEATS * 8;
    localparam int RESET_CYCLES = 8;

    // One FIU write beat as the host should see it
    typedef struct packed
    {
        logic     sop;
        cl_addr_t addr;
        cl_len_t  len;
        cl_data_t data;
    } beat_t;

    logic     clk;
    logic     reset;
    logic     afu_c0_valid;
    cl_addr_t afu_c0_addr;
    cl_len_t  afu_c0_len;
    logic     afu_c0_alm_full;
    logic     afu_c1_valid;
    logic     afu_c1_sop;
    cl_addr_t afu_c1_addr;
    cl_len_t  afu_c1_len;
    cl_data_t afu_c1_data;
    logic     afu_c1_alm_full;
    logic     fiu_c0_valid;
    cl_addr_t fiu_c0_addr;
    cl_len_t  fiu_c0_len;
    logic     fiu_c0_alm_full;
    logic     fiu_c1_valid;
    logic     fiu_c1_sop;
    cl_addr_t fiu_c1_addr;
    cl_len_t  fiu_c1_len;
    cl_data_t fiu_c1_data;
    logic     fiu_c1_alm_full;

    // Reference model state
    beat_t       exp_q[$];
    logic        prev_c0_valid;
    cl_addr_t    prev_c0_addr;
    cl_len_t     prev_c0_len;
    int          beats_left;
    int          stall_beats;
    int          stall_left;
    logic        host_stall_on;
    logic        checking;
    logic [15:0] lfsr;
    int          errors;
    int          reads_checked;
    int          beats_checked;
    int          cycles;

    mpf_edge_top i_dut
    (
        .clk             (clk),
        .reset           (reset),
        .afu_c0_valid    (afu_c0_valid),
        .afu_c0_addr     (afu_c0_addr),
        .afu_c0_len      (afu_c0_len),
        .afu_c0_alm_full (afu_c0_alm_full),
        .afu_c1_valid    (afu_c1_valid),
        .afu_c1_sop      (afu_c1_sop),
        .afu_c1_addr     (afu_c1_addr),
        .afu_c1_len      (afu_c1_len),
        .afu_c1_data     (afu_c1_data),
        .afu_c1_alm_full (afu_c1_alm_full),
        .fiu_c0_valid    (fiu_c0_valid),
        .fiu_c0_addr     (fiu_c0_addr),
        .fiu_c0_len      (fiu_c0_len),
        .fiu_c0_alm_full (fiu_c0_alm_full),
        .fiu_c1_valid    (fiu_c1_valid),
        .fiu_c1_sop      (fiu_c1_sop),
        .fiu_c1_addr     (fiu_c1_addr),
        .fiu_c1_len      (fiu_c1_len),
        .fiu_c1_data     (fiu_c1_data),
        .fiu_c1_alm_full (fiu_c1_alm_full)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // ========================================================================
    // Random source and small helpers
    // ========================================================================

    // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1 that steps once per bit
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[62:0], fb};
        end
        return r;
    endfunction

    // Length 2 is illegal, so it is folded onto the four-beat case
    function automatic cl_len_t legal_len();
        logic [1:0] v;
        v = rand_bits(2);
        return (v == 2'd2) ? 2'd3 : v;
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        errors++;
        $display("Fail %s: expected %h, got %h", name, expected, actual);
    endtask

    task automatic report_problem(input string what);
        errors++;
        $display("%s", what);
    endtask

    // ========================================================================
    // Stimulus
    // ========================================================================

    // Starts a new cycle just after the edge and leaves the valids low until a
    // task sets them
    task automatic step_cycle();
        @(posedge clk);
        #1;
        afu_c0_valid = 1'b0;
        afu_c1_valid = 1'b0;
        // Host stalls come in runs so that long holds are exercised too
        if (stall_left != 0)
            stall_left--;
        else if (rand_bits(3) == 0)
            stall_left = 2 + int'(rand_bits(3));
        fiu_c1_alm_full = host_stall_on && (stall_left != 0);
        fiu_c0_alm_full = (rand_bits(2) == 0);
    endtask

    task automatic send_read();
        step_cycle();
        afu_c0_valid = 1'b1;
        afu_c0_addr  = cl_addr_t'(rand_bits(32));
        afu_c0_len   = legal_len();
    endtask

    task automatic send_write();
        cl_len_t  len;
        cl_addr_t base;
        cl_data_t data;
        // Almost-full is only looked at before the start beat
        step_cycle();
        while (afu_c1_alm_full)
            step_cycle();
        len  = legal_len();
        base = cl_addr_t'(rand_bits(32)) & ~cl_addr_t'(len);
        for (int k = 0; k <= int'(len); k++)
        begin
            // Gaps between beats make the FIU side wait for heap data
            if (k != 0)
            begin
                step_cycle();
                while (rand_bits(2) == 0)
                    step_cycle();
            end
            data         = rand_bits(64);
            afu_c1_valid = 1'b1;
            afu_c1_sop   = (k == 0);
            afu_c1_addr  = base | cl_addr_t'(k);
            afu_c1_len   = len;
            afu_c1_data  = data;
            exp_q.push_back({(k == 0), base | cl_addr_t'(k), len, data});
        end
    endtask

    // ========================================================================
    // Checks are sampled mid-cycle where every output is stable
    // ========================================================================

    task automatic check_reset_state();
        assert (fiu_c0_valid == 1'b0) else report_mismatch("fiu_c0_valid", 0, fiu_c0_valid);
        assert (fiu_c1_valid == 1'b0) else report_mismatch("fiu_c1_valid", 0, fiu_c1_valid);
        assert (afu_c1_alm_full == 1'b0)
            else report_mismatch("afu_c1_alm_full", 0, afu_c1_alm_full);
    endtask

    // A read shows up on the FIU exactly one cycle after the AFU gave it
    task automatic check_reads();
        assert (fiu_c0_valid == prev_c0_valid)
            else report_mismatch("fiu_c0_valid", prev_c0_valid, fiu_c0_valid);
        if (prev_c0_valid && fiu_c0_valid)
        begin
            reads_checked++;
            assert (fiu_c0_addr == prev_c0_addr)
                else report_mismatch("fiu_c0_addr", prev_c0_addr, fiu_c0_addr);
            assert (fiu_c0_len == prev_c0_len)
                else report_mismatch("fiu_c0_len", prev_c0_len, fiu_c0_len);
        end
        assert (afu_c0_alm_full == fiu_c0_alm_full)
            else report_mismatch("afu_c0_alm_full", fiu_c0_alm_full, afu_c0_alm_full);
        prev_c0_valid = afu_c0_valid;
        prev_c0_addr  = afu_c0_addr;
        prev_c0_len   = afu_c0_len;
    endtask

    task automatic check_writes();
        beat_t exp;
        if (fiu_c1_valid)
        begin
            assert (exp_q.size() != 0)
                else report_problem("An FIU write beat appeared with no AFU beat left to match");
            if (exp_q.size() != 0)
            begin
                exp = exp_q.pop_front();
                beats_checked++;
                assert (fiu_c1_sop == exp.sop)
                    else report_mismatch("fiu_c1_sop", exp.sop, fiu_c1_sop);
                assert (fiu_c1_addr == exp.addr)
                    else report_mismatch("fiu_c1_addr", exp.addr, fiu_c1_addr);
                assert (fiu_c1_len == exp.len)
                    else report_mismatch("fiu_c1_len", exp.len, fiu_c1_len);
                assert (fiu_c1_data == exp.data)
                    else report_mismatch("fiu_c1_data", exp.data, fiu_c1_data);
            end
        end
    endtask

    task automatic check_flow();
        // At most two beats already in the heap read pipeline may still drain
        if (fiu_c1_alm_full)
        begin
            if (fiu_c1_valid)
                stall_beats++;
            assert (stall_beats <= 2)
                else report_problem("More than 2 FIU write beats came while the host was full");
        end
        else
            stall_beats = 0;
        assert (!(afu_c1_alm_full && beats_left != 0))
            else report_problem("afu_c1_alm_full was raised in the middle of a write packet");
        if (afu_c1_valid)
            beats_left = afu_c1_sop ? int'(afu_c1_len) : beats_left - 1;
    endtask

    always @(negedge clk)
    begin
        if (checking)
        begin
            check_reads();
            check_writes();
            check_flow();
        end
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("Timeout after %0d cycles with %0d write beats outstanding",
                     cycles, exp_q.size());
            $display("Simulation failed");
            $finish;
        end
    end

    // ========================================================================
    // Main sequence
    // ========================================================================

    initial
    begin
        lfsr            = 16'd9288;
        errors          = 0;
        reads_checked   = 0;
        beats_checked   = 0;
        cycles          = 0;
        checking        = 1'b0;
        prev_c0_valid   = 1'b0;
        prev_c0_addr    = '0;
        prev_c0_len     = '0;
        beats_left      = 0;
        stall_beats     = 0;
        stall_left      = 0;
        host_stall_on   = 1'b1;
        reset           = 1'b1;
        afu_c0_valid    = 1'b0;
        afu_c0_addr     = '0;
        afu_c0_len      = '0;
        afu_c1_valid    = 1'b0;
        afu_c1_sop      = 1'b0;
        afu_c1_addr     = '0;
        afu_c1_len      = '0;
        afu_c1_data     = '0;
        fiu_c0_alm_full = 1'b0;
        fiu_c1_alm_full = 1'b0;

        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b0;
        checking = 1'b1;
        @(negedge clk);
        check_reset_state();

        // Writes dominate because they carry the interesting behavior
        for (int r = 0; r < N_REQUESTS; r++)
        begin
            if (rand_bits(2) == 0)
                send_read();
            else
                send_write();
            while (rand_bits(2) == 0)
                step_cycle();
        end

        // Let the host take everything and then watch for stray beats
        host_stall_on = 1'b0;
        step_cycle();
        while (exp_q.size() != 0)
            step_cycle();
        repeat (8) step_cycle();

        $display("Reads checked %0d, write beats checked %0d, errors %0d",
                 reads_checked, beats_checked, errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// ==== files.f ====
design/mpf_pkg.sv
design/mpf_chan_if.sv
design/write_data_heap.sv
design/lutram_fifo.sv
design/multi_write_tracker.sv
design/edge_connect.sv
design/mpf_edge_top.sv
testbench/tb_mpf_edge.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_mpf_edge -f files.f \
    > build.log 2>&1 || { cat build.log; echo "Build error"; exit 1; }

./obj_dir/Vtb_mpf_edge > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

grep -q "Simulation failed" sim.log && exit 1
grep -q "Simulation completed successfully" sim.log || exit 1
exit 0
